// ==== src/mips_load_pkg.sv ====
`default_nettype none

package mips_load_pkg;

  // ####################
  // Opcodes and status
  // ####################

  typedef enum logic [2:0] {
    OP_LW,
    OP_LB,
    OP_LBU,
    OP_LH,
    OP_LHU,
    OP_LWL,
    OP_LWR
  } load_op_e;

  typedef enum logic [1:0] {
    FAULT_NONE,
    FAULT_ALIGN,
    FAULT_BUS,
    FAULT_TIMEOUT
  } load_fault_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_WRITE
  } load_state_e;

  // ####################
  // Sizes
  // ####################

  localparam int REG_COUNT  = 32;
  localparam int REG_ADDR_W = 5;
  localparam int DATA_W     = 32;
  localparam int WB_ADR_W   = 30;
  localparam int REG_V0     = 2;

  // Watchdog limit and its counter
  localparam int BUS_TIMEOUT_CYCLES = 16;
  localparam int WDOG_CNT_W = $clog2(BUS_TIMEOUT_CYCLES);
  localparam logic [WDOG_CNT_W-1:0] WDOG_LAST = WDOG_CNT_W'(BUS_TIMEOUT_CYCLES - 1);

endpackage

`default_nettype wire

// ==== src/reg_write_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface reg_write_if;

  logic                                  write_enable;
  logic [mips_load_pkg::REG_ADDR_W-1:0] rd;
  logic [mips_load_pkg::DATA_W-1:0]     data;
  // Low address bits select the lwl/lwr byte lanes
  logic [1:0]                            byte_addressing;
  logic                                  lwl;
  logic                                  lwr;

  modport producer (
    output write_enable,
    output rd,
    output data,
    output byte_addressing,
    output lwl,
    output lwr
  );

  modport consumer (
    input write_enable,
    input rd,
    input data,
    input byte_addressing,
    input lwl,
    input lwr
  );

endinterface

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  logic                                  clk,
  input  logic                                  reset,
  reg_write_if.consumer                         write,
  input  logic [mips_load_pkg::REG_ADDR_W-1:0] base_sel,
  input  logic [mips_load_pkg::REG_ADDR_W-1:0] rd_sel,
  output logic [mips_load_pkg::DATA_W-1:0]     base_data,
  output logic [mips_load_pkg::DATA_W-1:0]     rd_data,
  output logic [mips_load_pkg::DATA_W-1:0]     register_v0
);

  logic [mips_load_pkg::DATA_W-1:0] regs [mips_load_pkg::REG_COUNT];
  logic [mips_load_pkg::DATA_W-1:0] old_value;
  logic [mips_load_pkg::DATA_W-1:0] merged;

  assign base_data   = regs[base_sel];
  assign rd_data     = regs[rd_sel];
  assign register_v0 = regs[mips_load_pkg::REG_V0];

  // ####################
  // Byte merge
  // ####################

  // lwl fills the register from the top down and lwr from the bottom up
  always_comb begin
    old_value = regs[write.rd];
    merged    = write.data;
    if (write.lwl) begin
      case (write.byte_addressing)
        2'b00:   merged = {write.data[7:0], old_value[23:0]};
        2'b01:   merged = {write.data[15:0], old_value[15:0]};
        2'b10:   merged = {write.data[23:0], old_value[7:0]};
        default: merged = write.data;
      endcase
    end else if (write.lwr) begin
      case (write.byte_addressing)
        2'b00:   merged = write.data;
        2'b01:   merged = {old_value[31:24], write.data[31:8]};
        2'b10:   merged = {old_value[31:16], write.data[31:16]};
        default: merged = {old_value[31:8], write.data[31:24]};
      endcase
    end
  end

  // ####################
  // Storage
  // ####################

  // Register 0 is never written so it stays at its reset value of zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < mips_load_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write.write_enable && write.rd != '0) begin
      regs[write.rd] <= merged;
    end
  end

  // The aligner decodes one opcode per write, never both partial loads
  assert property (@(posedge clk) disable iff (reset)
    write.write_enable |-> !(write.lwl && write.lwr));

endmodule

`default_nettype wire

// ==== src/load_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_align (
  input  mips_load_pkg::load_op_e               op,
  input  logic [mips_load_pkg::REG_ADDR_W-1:0] rt,
  input  logic [1:0]                            byte_offset,
  input  logic [mips_load_pkg::DATA_W-1:0]     mem_data,
  input  logic                                  commit,
  reg_write_if.producer                         write
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // Memory words are little-endian, byte 0 sits in bits 7:0
  always_comb begin
    sel_byte = mem_data[{byte_offset, 3'b000} +: 8];
    if (byte_offset[1]) begin
      sel_half = mem_data[31:16];
    end else begin
      sel_half = mem_data[15:0];
    end
  end

  // ####################
  // Extension
  // ####################

  always_comb begin
    case (op)
      mips_load_pkg::OP_LB: begin
        write.data = {{(mips_load_pkg::DATA_W - 8){sel_byte[7]}}, sel_byte};
      end
      mips_load_pkg::OP_LBU: begin
        write.data = {{(mips_load_pkg::DATA_W - 8){1'b0}}, sel_byte};
      end
      mips_load_pkg::OP_LH: begin
        write.data = {{(mips_load_pkg::DATA_W - 16){sel_half[15]}}, sel_half};
      end
      mips_load_pkg::OP_LHU: begin
        write.data = {{(mips_load_pkg::DATA_W - 16){1'b0}}, sel_half};
      end
      // lw, lwl and lwr pass the whole word; the register file merges
      default: begin
        write.data = mem_data;
      end
    endcase
  end

  // ####################
  // Write request
  // ####################

  assign write.write_enable    = commit;
  assign write.rd              = rt;
  assign write.byte_addressing = byte_offset;
  assign write.lwl             = (op == mips_load_pkg::OP_LWL);
  assign write.lwr             = (op == mips_load_pkg::OP_LWR);

endmodule

`default_nettype wire

// ==== src/bus_watchdog.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_watchdog (
  input  logic clk,
  input  logic reset,
  input  logic active,
  output logic expired
);

  logic [mips_load_pkg::WDOG_CNT_W-1:0] count;

  // The count restarts whenever the bus cycle ends
  always_ff @(posedge clk) begin
    if (reset || !active) begin
      count   <= '0;
      expired <= 1'b0;
    end else if (!expired) begin
      count   <= count + 1'b1;
      expired <= (count == mips_load_pkg::WDOG_LAST);
    end
  end

  // A bus access left open for the full limit is flagged on the next cycle
  assert property (@(posedge clk) disable iff (reset)
    active [*mips_load_pkg::BUS_TIMEOUT_CYCLES] |=> expired);

endmodule

`default_nettype wire

// ==== src/load_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_ctrl (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  issue_valid,
  input  mips_load_pkg::load_op_e               issue_op,
  input  logic [mips_load_pkg::REG_ADDR_W-1:0] issue_rt,
  input  logic [15:0]                           issue_offset,
  input  logic [mips_load_pkg::DATA_W-1:0]     base_data,
  output logic                                  busy,
  output logic                                  done,
  output mips_load_pkg::load_fault_e            fault,
  output logic [mips_load_pkg::WB_ADR_W-1:0]   wb_adr,
  output logic                                  wb_cyc,
  output logic                                  wb_stb,
  input  logic                                  wb_ack,
  input  logic                                  wb_err,
  input  logic [mips_load_pkg::DATA_W-1:0]     wb_dat_r,
  input  logic                                  watchdog_expired,
  output logic                                  bus_active,
  output mips_load_pkg::load_op_e               op,
  output logic [mips_load_pkg::REG_ADDR_W-1:0] rt,
  output logic [1:0]                            byte_offset,
  output logic [mips_load_pkg::DATA_W-1:0]     mem_data,
  output logic                                  commit
);

  mips_load_pkg::load_state_e       state;
  mips_load_pkg::load_fault_e       fault_q;
  logic [mips_load_pkg::DATA_W-1:0] addr_q;
  logic [mips_load_pkg::DATA_W-1:0] issue_addr;
  logic                             misaligned;

  // ####################
  // Address check
  // ####################

  always_comb begin
    issue_addr = base_data + {{16{issue_offset[15]}}, issue_offset};
    case (issue_op)
      mips_load_pkg::OP_LW:  misaligned = (issue_addr[1:0] != 2'b00);
      mips_load_pkg::OP_LH:  misaligned = issue_addr[0];
      mips_load_pkg::OP_LHU: misaligned = issue_addr[0];
      default:               misaligned = 1'b0;
    endcase
  end

  // ####################
  // FSM
  // ####################

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= mips_load_pkg::ST_IDLE;
      fault_q <= mips_load_pkg::FAULT_NONE;
    end else begin
      case (state)
        mips_load_pkg::ST_IDLE: begin
          if (issue_valid && misaligned) begin
            state   <= mips_load_pkg::ST_WRITE;
            fault_q <= mips_load_pkg::FAULT_ALIGN;
          end else if (issue_valid) begin
            state   <= mips_load_pkg::ST_BUS;
            fault_q <= mips_load_pkg::FAULT_NONE;
          end
        end
        mips_load_pkg::ST_BUS: begin
          // An ack wins over err if a slave ever drives both
          if (wb_ack) begin
            state   <= mips_load_pkg::ST_WRITE;
            fault_q <= mips_load_pkg::FAULT_NONE;
          end else if (wb_err) begin
            state   <= mips_load_pkg::ST_WRITE;
            fault_q <= mips_load_pkg::FAULT_BUS;
          end else if (watchdog_expired) begin
            state   <= mips_load_pkg::ST_WRITE;
            fault_q <= mips_load_pkg::FAULT_TIMEOUT;
          end
        end
        default: begin
          state <= mips_load_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Load payload, held for the whole transaction
  always_ff @(posedge clk) begin
    if (state == mips_load_pkg::ST_IDLE && issue_valid) begin
      addr_q <= issue_addr;
      op     <= issue_op;
      rt     <= issue_rt;
    end
    if (state == mips_load_pkg::ST_BUS && wb_ack) begin
      mem_data <= wb_dat_r;
    end
  end

  // ####################
  // Outputs
  // ####################

  assign busy        = (state != mips_load_pkg::ST_IDLE);
  assign done        = (state == mips_load_pkg::ST_WRITE);
  assign fault       = fault_q;
  assign commit      = done && (fault_q == mips_load_pkg::FAULT_NONE);
  assign bus_active  = (state == mips_load_pkg::ST_BUS);
  assign wb_cyc      = bus_active;
  assign wb_stb      = bus_active;
  assign wb_adr      = addr_q[mips_load_pkg::DATA_W-1:2];
  assign byte_offset = addr_q[1:0];

  // The bus cycle closes at the edge where the slave answers
  assert property (@(posedge clk) disable iff (reset)
    wb_cyc && (wb_ack || wb_err) |=> !wb_cyc && !wb_stb);

endmodule

`default_nettype wire

// ==== src/mips_load_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_load_unit (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  issue_valid,
  input  mips_load_pkg::load_op_e               issue_op,
  input  logic [mips_load_pkg::REG_ADDR_W-1:0] issue_base,
  input  logic [mips_load_pkg::REG_ADDR_W-1:0] issue_rt,
  input  logic [15:0]                           issue_offset,
  output logic                                  busy,
  output logic                                  done,
  output mips_load_pkg::load_fault_e            fault,
  input  logic [mips_load_pkg::REG_ADDR_W-1:0] rd_sel,
  output logic [mips_load_pkg::DATA_W-1:0]     rd_data,
  output logic [mips_load_pkg::DATA_W-1:0]     register_v0,
  output logic [mips_load_pkg::WB_ADR_W-1:0]   wb_adr,
  output logic                                  wb_cyc,
  output logic                                  wb_stb,
  input  logic                                  wb_ack,
  input  logic                                  wb_err,
  input  logic [mips_load_pkg::DATA_W-1:0]     wb_dat_r
);

  logic [mips_load_pkg::DATA_W-1:0]     base_data;
  logic                                  watchdog_expired;
  logic                                  bus_active;
  mips_load_pkg::load_op_e               op;
  logic [mips_load_pkg::REG_ADDR_W-1:0] rt;
  logic [1:0]                            byte_offset;
  logic [mips_load_pkg::DATA_W-1:0]     mem_data;
  logic                                  commit;

  reg_write_if reg_write ();

  load_ctrl load_ctrl_i (
    .clk              (clk),
    .reset            (reset),
    .issue_valid      (issue_valid),
    .issue_op         (issue_op),
    .issue_rt         (issue_rt),
    .issue_offset     (issue_offset),
    .base_data        (base_data),
    .busy             (busy),
    .done             (done),
    .fault            (fault),
    .wb_adr           (wb_adr),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_ack           (wb_ack),
    .wb_err           (wb_err),
    .wb_dat_r         (wb_dat_r),
    .watchdog_expired (watchdog_expired),
    .bus_active       (bus_active),
    .op               (op),
    .rt               (rt),
    .byte_offset      (byte_offset),
    .mem_data         (mem_data),
    .commit           (commit)
  );

  bus_watchdog bus_watchdog_i (
    .clk     (clk),
    .reset   (reset),
    .active  (bus_active),
    .expired (watchdog_expired)
  );

  load_align load_align_i (
    .op          (op),
    .rt          (rt),
    .byte_offset (byte_offset),
    .mem_data    (mem_data),
    .commit      (commit),
    .write       (reg_write.producer)
  );

  // The base register is looked up straight from the issue port
  register_file register_file_i (
    .clk         (clk),
    .reset       (reset),
    .write       (reg_write.consumer),
    .base_sel    (issue_base),
    .rd_sel      (rd_sel),
    .base_data   (base_data),
    .rd_data     (rd_data),
    .register_v0 (register_v0)
  );

endmodule

`default_nettype wire

// ==== tb/tb_mips_load_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mips_load_unit;

  localparam int MAX_ROWS   = 80;
  localparam int WAIT_LIMIT = 4 * mips_load_pkg::BUS_TIMEOUT_CYCLES;

  logic                                  clk;
  logic                                  reset;
  logic                                  issue_valid;
  mips_load_pkg::load_op_e               issue_op;
  logic [mips_load_pkg::REG_ADDR_W-1:0] issue_base;
  logic [mips_load_pkg::REG_ADDR_W-1:0] issue_rt;
  logic [15:0]                           issue_offset;
  logic                                  busy;
  logic                                  done;
  mips_load_pkg::load_fault_e            fault;
  logic [mips_load_pkg::REG_ADDR_W-1:0] rd_sel;
  logic [mips_load_pkg::DATA_W-1:0]     rd_data;
  logic [mips_load_pkg::DATA_W-1:0]     register_v0;
  logic [mips_load_pkg::WB_ADR_W-1:0]   wb_adr;
  logic                                  wb_cyc;
  logic                                  wb_stb;
  logic                                  wb_ack;
  logic                                  wb_err;
  logic [mips_load_pkg::DATA_W-1:0]     wb_dat_r;

  logic [31:0] mem [64];
  int          delay_table [64];
  logic [31:0] model_regs [32];
  logic        cyc_seen;
  logic [mips_load_pkg::WB_ADR_W-1:0] adr_seen;
  int          value_errors;
  int          other_errors;
  logic        hung;

  // Stimulus table, one entry per load
  mips_load_pkg::load_op_e    row_op [MAX_ROWS];
  logic [4:0]                 row_base [MAX_ROWS];
  logic [4:0]                 row_rt [MAX_ROWS];
  logic [15:0]                row_offset [MAX_ROWS];
  mips_load_pkg::load_fault_e row_fault [MAX_ROWS];
  logic                       row_check [MAX_ROWS];
  int                         row_count;

  mips_load_unit mips_load_unit_i (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_base   (issue_base),
    .issue_rt     (issue_rt),
    .issue_offset (issue_offset),
    .busy         (busy),
    .done         (done),
    .fault        (fault),
    .rd_sel       (rd_sel),
    .rd_data      (rd_data),
    .register_v0  (register_v0),
    .wb_adr       (wb_adr),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .wb_err       (wb_err),
    .wb_dat_r     (wb_dat_r)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ####################
  // Wishbone memory
  // ####################

  // Word 60 answers with err and word 61 never answers
  initial begin : wishbone_slave
    int   wait_left;
    int   access_count;
    logic pending;
    wb_ack       = 1'b0;
    wb_err       = 1'b0;
    wb_dat_r     = '0;
    pending      = 1'b0;
    wait_left    = 0;
    access_count = 0;
    forever begin
      @(posedge clk);
      #1;
      wb_ack = 1'b0;
      wb_err = 1'b0;
      if (!(wb_cyc && wb_stb)) begin
        pending = 1'b0;
      end else begin
        if (!pending) begin
          pending   = 1'b1;
          wait_left = delay_table[access_count % 64];
          access_count++;
        end
        if (wait_left > 0) begin
          wait_left--;
        end else if (wb_adr == 30'd60) begin
          wb_err = 1'b1;
        end else if (wb_adr != 30'd61) begin
          wb_dat_r = mem[wb_adr[5:0]];
          wb_ack   = 1'b1;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (wb_cyc) begin
      cyc_seen = 1'b1;
      adr_seen = wb_adr;
    end
    if (wb_stb && !wb_cyc) begin
      $display("wb_stb was high outside a bus cycle");
      other_errors++;
    end
  end

  // ####################
  // Compare tasks
  // ####################

  task automatic check_data(input string name, input logic [mips_load_pkg::DATA_W-1:0] got,
                            input logic [mips_load_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_fault(input string name, input mips_load_pkg::load_fault_e got,
                             input mips_load_pkg::load_fault_e exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_adr(input string name, input logic [mips_load_pkg::WB_ADR_W-1:0] got,
                           input logic [mips_load_pkg::WB_ADR_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  // ####################
  // Reference model
  // ####################

  // Byte k of a word sits in bits 8k+7:8k
  function automatic logic [31:0] load_result(input mips_load_pkg::load_op_e op,
                                              input logic [31:0] old_value,
                                              input logic [31:0] word,
                                              input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] r;
    int          k;
    int          n;
    n = int'(off);
    b = 8'(word >> (8 * n));
    h = off[1] ? word[31:16] : word[15:0];
    r = old_value;
    case (op)
      mips_load_pkg::OP_LB:  r = {{24{b[7]}}, b};
      mips_load_pkg::OP_LBU: r = {24'h0, b};
      mips_load_pkg::OP_LH:  r = {{16{h[15]}}, h};
      mips_load_pkg::OP_LHU: r = {16'h0, h};
      mips_load_pkg::OP_LWL: begin
        for (k = 0; k <= n; k++) begin
          r[8 * (3 - n + k) +: 8] = word[8 * k +: 8];
        end
      end
      mips_load_pkg::OP_LWR: begin
        for (k = 0; k <= 3 - n; k++) begin
          r[8 * k +: 8] = word[8 * (k + n) +: 8];
        end
      end
      default: r = word;
    endcase
    return r;
  endfunction

  task automatic add_row(input mips_load_pkg::load_op_e op, input logic [4:0] base,
                         input logic [4:0] rt, input logic [15:0] offset,
                         input mips_load_pkg::load_fault_e exp_fault, input logic check);
    row_op[row_count]     = op;
    row_base[row_count]   = base;
    row_rt[row_count]     = rt;
    row_offset[row_count] = offset;
    row_fault[row_count]  = exp_fault;
    row_check[row_count]  = check;
    row_count++;
  endtask

  task automatic build_table();
    int i;
    int j;
    // Pointer in word 1, then loads through it
    add_row(mips_load_pkg::OP_LW, 5'd0, 5'd3, 16'h0004, mips_load_pkg::FAULT_NONE, 1'b1);
    add_row(mips_load_pkg::OP_LW, 5'd3, 5'd4, 16'h0008, mips_load_pkg::FAULT_NONE, 1'b1);
    add_row(mips_load_pkg::OP_LW, 5'd3, 5'd5, 16'hFFFC, mips_load_pkg::FAULT_NONE, 1'b1);
    for (i = 0; i < 4; i++) begin
      add_row(mips_load_pkg::OP_LB, 5'd0, 5'd6, 16'(32'h40 + i),
              mips_load_pkg::FAULT_NONE, 1'b1);
      add_row(mips_load_pkg::OP_LBU, 5'd0, 5'd7, 16'(32'h40 + i),
              mips_load_pkg::FAULT_NONE, 1'b1);
      add_row(mips_load_pkg::OP_LH, 5'd0, 5'd6, 16'(32'h40 + 2 * i),
              mips_load_pkg::FAULT_NONE, 1'b1);
      add_row(mips_load_pkg::OP_LHU, 5'd0, 5'd7, 16'(32'h40 + 2 * i),
              mips_load_pkg::FAULT_NONE, 1'b1);
    end
    // Each lwl offset followed by each lwr offset into one register
    for (i = 0; i < 4; i++) begin
      for (j = 0; j < 4; j++) begin
        add_row(mips_load_pkg::OP_LWL, 5'd0, 5'd8, 16'(32'h50 + i),
                mips_load_pkg::FAULT_NONE, 1'b1);
        add_row(mips_load_pkg::OP_LWR, 5'd0, 5'd8, 16'(32'h54 + j),
                mips_load_pkg::FAULT_NONE, 1'b1);
      end
    end
    add_row(mips_load_pkg::OP_LW, 5'd0, 5'd0, 16'h0030, mips_load_pkg::FAULT_NONE, 1'b1);
    add_row(mips_load_pkg::OP_LW, 5'd0, 5'd2, 16'h0034, mips_load_pkg::FAULT_NONE, 1'b1);
    add_row(mips_load_pkg::OP_LW, 5'd0, 5'd9, 16'h0044, mips_load_pkg::FAULT_NONE, 1'b1);
    add_row(mips_load_pkg::OP_LW, 5'd0, 5'd9, 16'h0041, mips_load_pkg::FAULT_ALIGN, 1'b1);
    add_row(mips_load_pkg::OP_LW, 5'd0, 5'd9, 16'h0046, mips_load_pkg::FAULT_ALIGN, 1'b1);
    add_row(mips_load_pkg::OP_LH, 5'd3, 5'd9, 16'h0023, mips_load_pkg::FAULT_ALIGN, 1'b1);
    add_row(mips_load_pkg::OP_LHU, 5'd0, 5'd9, 16'h0045, mips_load_pkg::FAULT_ALIGN, 1'b1);
    add_row(mips_load_pkg::OP_LW, 5'd0, 5'd9, 16'h00F0, mips_load_pkg::FAULT_BUS, 1'b1);
    add_row(mips_load_pkg::OP_LW, 5'd0, 5'd9, 16'h00F4, mips_load_pkg::FAULT_TIMEOUT, 1'b1);
  endtask

  // ####################
  // Row execution
  // ####################

  task automatic run_row(input int row);
    logic [31:0] addr;
    logic [31:0] word;
    int          cycles;
    addr = model_regs[row_base[row]] + {{16{row_offset[row][15]}}, row_offset[row]};
    word = mem[addr[7:2]];
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (busy && cycles < WAIT_LIMIT);
    if (busy) begin
      $display("Unit still busy before row %0d could be issued", row);
      other_errors++;
      hung = 1'b1;
      return;
    end
    issue_op     = row_op[row];
    issue_base   = row_base[row];
    issue_rt     = row_rt[row];
    issue_offset = row_offset[row];
    issue_valid  = 1'b1;
    cyc_seen     = 1'b0;
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
    cycles = 0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!done) begin
      $display("No done for row %0d within %0d cycles", row, WAIT_LIMIT);
      other_errors++;
      hung = 1'b1;
      return;
    end
    check_fault($sformatf("fault row %0d", row), fault, row_fault[row]);
    if (row_fault[row] == mips_load_pkg::FAULT_ALIGN) begin
      if (cyc_seen) begin
        $display("Row %0d started a bus cycle for a misaligned load", row);
        other_errors++;
      end
    end else if (!cyc_seen) begin
      $display("Row %0d finished without any bus cycle", row);
      other_errors++;
    end else begin
      check_adr($sformatf("wb_adr row %0d", row), adr_seen, addr[31:2]);
    end
    if (row_fault[row] == mips_load_pkg::FAULT_NONE && row_rt[row] != 5'd0) begin
      model_regs[row_rt[row]] = load_result(row_op[row], model_regs[row_rt[row]], word,
                                            addr[1:0]);
    end
    @(posedge clk);
    #1;
    rd_sel = row_rt[row];
    #1;
    check_bit($sformatf("done row %0d", row), done, 1'b0);
    if (row_check[row]) begin
      check_data($sformatf("rd_data r%0d row %0d", row_rt[row], row), rd_data,
                 model_regs[row_rt[row]]);
    end
    check_data($sformatf("register_v0 row %0d", row), register_v0,
               model_regs[mips_load_pkg::REG_V0]);
  endtask

  initial begin : main
    int i;
    issue_valid  = 1'b0;
    issue_op     = mips_load_pkg::OP_LW;
    issue_base   = '0;
    issue_rt     = '0;
    issue_offset = '0;
    rd_sel       = '0;
    reset        = 1'b1;
    value_errors = 0;
    other_errors = 0;
    hung         = 1'b0;
    row_count    = 0;
    cyc_seen     = 1'b0;
    adr_seen     = '0;
    void'($urandom(36));
    for (i = 0; i < 64; i++) begin
      mem[i]         = $urandom();
      delay_table[i] = $urandom_range(3, 0);
    end
    // A pointer word and words with known signs for the extension loads
    mem[1]  = 32'h0000_0020;
    mem[16] = 32'h8a7f_c355;
    mem[17] = 32'h7ffe_1234;
    for (i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    build_table();

    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    check_bit("wb_cyc", wb_cyc, 1'b0);
    check_bit("wb_stb", wb_stb, 1'b0);
    for (i = 0; i < 32; i++) begin
      @(posedge clk);
      #1;
      rd_sel = 5'(i);
      #1;
      check_data($sformatf("rd_data r%0d after reset", i), rd_data, '0);
    end

    for (i = 0; i < row_count && !hung; i++) begin
      run_row(i);
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
src/mips_load_pkg.sv
src/reg_write_if.sv
src/register_file.sv
src/load_align.sv
src/bus_watchdog.sv
src/load_ctrl.sv
src/mips_load_unit.sv
tb/tb_mips_load_unit.sv

// ==== Bender.yml ====
package:
  name: mips_load_unit

sources:
  - src/mips_load_pkg.sv
  - src/reg_write_if.sv
  - src/register_file.sv
  - src/load_align.sv
  - src/bus_watchdog.sv
  - src/load_ctrl.sv
  - src/mips_load_unit.sv
  - target: test
    files:
      - tb/tb_mips_load_unit.sv
